/* filelist.f */
+incdir+hdl
hdl/enc_pkg.sv
hdl/enc_quad_decoder.sv
hdl/enc_period_meas.sv
hdl/enc_apb_regs.sv
hdl/enc_top.sv
tests/enc_chk.sv
tests/enc_tb.sv

/* hdl/enc_apb_regs.sv */
// apb slave register file: encoder control, position and velocity status, no wait states
`include "enc_params.svh"

module enc_apb_regs (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`ENC_APB_AW-1:0]       paddr,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [31:0]                  pwdata,
  input  logic signed [`ENC_POS_W-1:0] position,
  input  enc_pkg::enc_vel_t            vel,
  output logic [31:0]                  prdata,
  output logic                         pready,
  output logic                         pslverr,
  output enc_pkg::enc_ctrl_t           ctrl
);

  // zero fill between a status bit in 31 and the interval field
  localparam int PAD_W = 31 - `ENC_PER_W;

  logic        access;    // apb access phase
  logic        wr_en;
  logic        rd_en;
  logic        mapped;    // paddr hits a register
  logic        sel_ctrl;
  logic [31:0] rd_data;   // muxed before the read gate

  assign access = psel & penable;
  assign wr_en  = access & pwrite;
  assign rd_en  = access & ~pwrite;

  assign sel_ctrl = (paddr == `ENC_ADDR_CTRL);

  // read mux and address decode
  always_comb begin
    rd_data = '0;
    mapped  = 1'b1;
    case (paddr)
      `ENC_ADDR_CTRL: begin
        rd_data = {31'd0, ctrl.enable};  // pos_clear reads 0
      end
      `ENC_ADDR_POS: begin
        rd_data = 32'(position);          // sign extends if narrower
      end
      `ENC_ADDR_PER: begin
        rd_data = {vel.ovf, {PAD_W{1'b0}}, vel.period};
      end
      `ENC_ADDR_PREV: begin
        rd_data = {vel.dir, {PAD_W{1'b0}}, vel.prev};
      end
      default: begin
        mapped = 1'b0;                    // also catches misaligned offsets
      end
    endcase
  end

  // bus outputs, only live in the access phase
  assign prdata  = rd_en ? rd_data : 32'd0;
  assign pready  = access;                // zero wait states
  assign pslverr = access & ~mapped;

  // ctrl register
  // writes to POS/PER/PREV fall through here and are dropped, no error
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl.enable    <= 1'b1;   // counting on out of reset
      ctrl.pos_clear <= 1'b0;
    end else begin
      ctrl.pos_clear <= 1'b0;   // pulse, self clearing
      if (wr_en && sel_ctrl) begin
        ctrl.enable    <= pwdata[0];
        ctrl.pos_clear <= pwdata[1];
      end
    end
  end

  // map, byte offsets
  //   0x0 CTRL  [0] enable rw, [1] pos_clear w1 pulse
  //   0x4 POS   signed position
  //   0x8 PER   [31] ovf, low bits period
  //   0xC PREV  [31] dir, low bits prev
  // ctrl write visible the cycle after the access edge
  // pos_clear reaches the decoder one cycle later still

endmodule

/* hdl/enc_params.svh */
// shared widths, timebase divider and apb offsets; include in any encoder file that needs them
`ifndef ENC_PARAMS_SVH
`define ENC_PARAMS_SVH

// signed position count, 4x decode
`define ENC_POS_W 32

// edge-to-edge interval counter width
`define ENC_PER_W 24

// interval counter stops here, in ticks
// well below 2**ENC_PER_W so a stalled axis shows ovf within a few thousand clk
`define ENC_PER_SAT 1000

// clk cycles per velocity timebase tick
`define ENC_TICK_DIV 4

// apb address width, byte offsets
`define ENC_APB_AW 8

`define ENC_ADDR_CTRL 8'h00  // enable, pos_clear
`define ENC_ADDR_POS  8'h04  // signed position
`define ENC_ADDR_PER  8'h08  // latest interval, ovf in bit 31
`define ENC_ADDR_PREV 8'h0C  // interval before, dir in bit 31

`endif

/* hdl/enc_period_meas.sv */
// period meter: ticks of a divided timebase between edges, saturating, with previous-interval capture
`include "enc_params.svh"

module enc_period_meas (
  input  logic               clk,
  input  logic               rst,
  input  enc_pkg::enc_edge_t edge_i,
  output enc_pkg::enc_vel_t  vel
);

  // prescaler width, at least one bit
  localparam int PRE_W = (`ENC_TICK_DIV > 1) ? $clog2(`ENC_TICK_DIV) : 1;
  localparam logic [PRE_W-1:0]      PRE_LAST = PRE_W'(`ENC_TICK_DIV - 1);
  localparam logic [`ENC_PER_W-1:0] PER_SAT  = `ENC_PER_W'(`ENC_PER_SAT);
  localparam logic [`ENC_PER_W-1:0] PER_ONE  = 1;

  logic [PRE_W-1:0]      pre_cnt;  // clk cycles within a tick
  logic                  tick;     // timebase strobe, one clk wide
  logic [`ENC_PER_W-1:0] run_cnt;  // ticks since last edge
  logic                  sat;      // run_cnt pinned at limit

  // prescaler, free running
  // replaces a separate slow clock, everything stays on clk
  always_ff @(posedge clk) begin
    if (rst) begin
      pre_cnt <= '0;
    end else if (tick) begin
      pre_cnt <= '0;
    end else begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  assign tick = (pre_cnt == PRE_LAST);

  assign sat = (run_cnt >= PER_SAT);

  // running interval
  // restarts on every edge, reversal included
  always_ff @(posedge clk) begin
    if (rst) begin
      run_cnt <= '0;
    end else if (edge_i.valid) begin
      run_cnt <= '0;
    end else if (tick && !sat) begin
      run_cnt <= run_cnt + PER_ONE;  // stops at PER_SAT
    end
  end

  // status registers, one cycle behind edge_i.valid
  always_ff @(posedge clk) begin
    if (rst) begin
      vel <= '0;
    end else if (edge_i.valid) begin
      vel.period <= run_cnt;      // interval just closed
      vel.prev   <= vel.period;   // shift older one along
      vel.dir    <= edge_i.dir;
      vel.ovf    <= 1'b0;         // new interval starts clean
    end else begin
      vel.ovf    <= sat;          // raised once the count is stuck
    end
  end

  // notes on resolution
  //   period is in ticks, so a spacing of S clk reads as S / ENC_TICK_DIV
  //   prescaler phase is not aligned to edges, hence +-1 tick jitter
  //   an edge with run_cnt at PER_SAT latches PER_SAT into period
  //   ovf follows sat by one cycle, and clears with the edge that ends the stall
  //
  // host side acceleration
  //   accel ~ (1/period - 1/prev) / period, done in software
  //   dir in vel tells it which sign to give the rate

endmodule

/* hdl/enc_pkg.sv */
// types passed between decoder, period meter and apb registers; import in any block using them
`include "enc_params.svh"

package enc_pkg;

  // one decoded quadrature step
  // valid is a single-cycle strobe, dir only meaningful with valid
  typedef struct packed {
    logic valid;  // one cycle per edge
    logic dir;    // 1 = forward, b leads a
  } enc_edge_t;

  // velocity status seen by the host
  // period and prev in timebase ticks, host forms accel from the pair
  typedef struct packed {
    logic [`ENC_PER_W-1:0] period;  // latest completed interval
    logic [`ENC_PER_W-1:0] prev;    // interval before that
    logic                  dir;     // direction of last edge
    logic                  ovf;     // running interval saturated
  } enc_vel_t;

  // control from the register file to the decoder
  typedef struct packed {
    logic enable;     // edges move the position
    logic pos_clear;  // single-cycle zeroing pulse
  } enc_ctrl_t;

  // field layout, msb first:
  //   enc_edge_t  {valid, dir}
  //   enc_vel_t   {period, prev, dir, ovf}
  //   enc_ctrl_t  {enable, pos_clear}
  //
  // ctrl.enable resets to 1, so the axis counts without host setup
  // ctrl.pos_clear wins over an edge arriving in the same cycle
  //
  // vel updates one cycle after edge.valid
  // a reversal is just another edge for the period meter
  //
  // all three cross block boundaries only inside enc_top
  // enc_top itself sees plain apb and pin signals

endpackage

/* hdl/enc_quad_decoder.sv */
// quadrature decoder: syncs a/b, decodes 4x gray steps, keeps direction and signed position
`include "enc_params.svh"

module enc_quad_decoder (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         a,
  input  logic                         b,
  input  enc_pkg::enc_ctrl_t           ctrl,
  output enc_pkg::enc_edge_t           edge_o,
  output logic signed [`ENC_POS_W-1:0] position
);

  localparam logic signed [`ENC_POS_W-1:0] POS_STEP = 1;  // one count per edge

  logic [1:0] sync1;    // {a, b}, first stage, may go metastable
  logic [1:0] sync2;    // {a, b}, settled, the new state
  logic [1:0] state_q;  // previous settled state
  logic       fwd;      // legal step, b leading
  logic       rev;      // legal step, a leading
  logic       step;

  // pins are asynchronous, two flops before any decode
  // state_q follows them through reset too, first decode after release sees no step
  always_ff @(posedge clk) begin
    sync1   <= {a, b};
    sync2   <= sync1;
    state_q <= sync2;
  end

  // gray transition table, old state then new state
  // forward order with b leading: 00 -> 01 -> 11 -> 10 -> 00
  always_comb begin
    fwd = 1'b0;
    rev = 1'b0;
    case ({state_q, sync2})
      4'b00_01,
      4'b01_11,
      4'b11_10,
      4'b10_00: fwd = 1'b1;   // b moved first
      4'b01_00,
      4'b11_01,
      4'b10_11,
      4'b00_10: rev = 1'b1;   // a moved first
      default: begin          // no change, or both lines flipped
        fwd = 1'b0;
        rev = 1'b0;
      end
    endcase
  end

  assign step = fwd | rev;

  // edge record, one-cycle strobe
  // still decoded while counting is disabled, period meter keeps running
  always_ff @(posedge clk) begin
    if (rst) begin
      edge_o <= '0;
    end else begin
      edge_o.valid <= step;
      if (step) begin
        edge_o.dir <= fwd;  // hold last direction between edges
      end
    end
  end

  // position counter, lands in the same cycle as edge_o.valid
  always_ff @(posedge clk) begin
    if (rst) begin
      position <= '0;
    end else if (ctrl.pos_clear) begin
      position <= '0;               // clear beats a coincident edge
    end else if (ctrl.enable) begin
      if (fwd) begin
        position <= position + POS_STEP;
      end else if (rev) begin
        position <= position - POS_STEP;
      end
    end
  end

endmodule

/* hdl/enc_top.sv */
// top level for one encoder axis: pins a/b in, apb slave out, joins decoder, period meter, registers
`include "enc_params.svh"

module enc_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   a,        // async encoder line a
  input  logic                   b,        // async encoder line b
  input  logic [`ENC_APB_AW-1:0] paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr
);
  import enc_pkg::*;

  enc_ctrl_t                    ctrl;      // regs -> decoder
  enc_edge_t                    edge_rec;  // decoder -> period meter
  enc_vel_t                     vel;       // period meter -> regs
  logic signed [`ENC_POS_W-1:0] position;  // decoder -> regs

  // 4x decode, pin change to position in 3 clk
  enc_quad_decoder i_dec (
    .clk      (clk),
    .rst      (rst),
    .a        (a),
    .b        (b),
    .ctrl     (ctrl),
    .edge_o   (edge_rec),
    .position (position)
  );

  // edge spacing in timebase ticks
  enc_period_meas i_per (
    .clk    (clk),
    .rst    (rst),
    .edge_i (edge_rec),
    .vel    (vel)
  );

  // host access, read data comb in the access cycle
  enc_apb_regs i_regs (
    .clk      (clk),
    .rst      (rst),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .position (position),
    .vel      (vel),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .ctrl     (ctrl)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the encoder testbench with Verilator, run it, and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module enc_tb -o enc_sim || exit 1

out=$(./obj_dir/enc_sim 2>&1)
echo "$out"

echo "$out" | grep -qx "All tests passed!" && exit 0 || exit 1

/* tests/enc_chk.sv */
// concurrent checks on decode, period measurement and apb handshake; bound into enc_top
`include "enc_params.svh"

module enc_chk (
  input logic                         clk,
  input logic                         rst,
  input logic                         psel,
  input logic                         penable,
  input logic                         pready,
  input logic                         pslverr,
  input enc_pkg::enc_ctrl_t           ctrl,
  input enc_pkg::enc_edge_t           edge_rec,
  input logic signed [`ENC_POS_W-1:0] position,
  input enc_pkg::enc_vel_t            vel
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic signed [`ENC_POS_W-1:0] POS_ONE = 1;
  localparam logic [`ENC_PER_W-1:0]        PER_MAX = `ENC_PER_W'(`ENC_PER_SAT);

  logic signed [`ENC_POS_W-1:0] step_exp;  // +1 forward, -1 reverse
  int                           fail_cnt = 0;  // read by the testbench at the end

  assign step_exp = edge_rec.dir ? POS_ONE : -POS_ONE;

  // counted edge moves position by one, sign from dir
  a_edge_step: assert property (@(posedge clk) disable iff (rst)
    (edge_rec.valid && $past(ctrl.enable) && !$past(ctrl.pos_clear))
    |-> (position == $past(position) + step_exp))
    else begin $error("edge did not move position by one step"); fail_cnt = fail_cnt + 1; end

  // disabled axis still decodes but holds the count
  a_edge_hold: assert property (@(posedge clk) disable iff (rst)
    (edge_rec.valid && !$past(ctrl.enable) && !$past(ctrl.pos_clear))
    |-> (position == $past(position)))
    else begin $error("position moved while disabled"); fail_cnt = fail_cnt + 1; end

  a_per_limit: assert property (@(posedge clk) disable iff (rst)
    (vel.period <= PER_MAX) && (vel.prev <= PER_MAX))
    else begin $error("interval above saturation value"); fail_cnt = fail_cnt + 1; end

  // status one cycle behind the edge
  a_vel_follow: assert property (@(posedge clk) disable iff (rst)
    edge_rec.valid |=> (vel.dir == $past(edge_rec.dir)) && !vel.ovf)
    else begin $error("velocity status did not follow edge"); fail_cnt = fail_cnt + 1; end

  a_pready: assert property (@(posedge clk) disable iff (rst)
    (psel && penable) |-> pready)
    else begin $error("pready low in access cycle"); fail_cnt = fail_cnt + 1; end

endmodule

bind enc_top enc_chk i_enc_chk (
  .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pready(pready),
  .pslverr(pslverr), .ctrl(ctrl), .edge_rec(edge_rec), .position(position), .vel(vel)
);

/* tests/enc_tb.sv */
// testbench for enc_top: generates a/b quadrature waveforms, drives apb, checks register reads
`include "enc_params.svh"

module enc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF   = 20;   // 40 ns period
  localparam int RST_CYCLES = 5;
  localparam int PIN_TO_REG = 4;    // pin change to readable position, worst case
  localparam int PREADY_MAX = 8;    // slave has no wait states, this is only a guard
  localparam int SAT_SPAN   = `ENC_PER_SAT * `ENC_TICK_DIV;  // clk until ovf
  localparam int MAX_CYCLES = 20000;  // tests need roughly 6k, idle span dominates

  logic                   clk;
  logic                   rst;
  logic                   a;
  logic                   b;
  logic [`ENC_APB_AW-1:0] paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;

  int    seed = 8044;
  int    cycles;
  int    enc_idx;    // place in the gray cycle
  int    exp_pos;    // model of the position count
  bit    counting;   // model of ctrl.enable
  string test_name;
  int    test_errs;
  int    tests_run;
  int    tests_failed;

  enc_top i_enc_top (
    .clk(clk), .rst(rst), .a(a), .b(b),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // {a, b} for a forward walk, b leads
  function automatic logic [1:0] gray_state(input int idx);
    case (idx)
      0: return 2'b00;
      1: return 2'b01;
      2: return 2'b11;
      default: return 2'b10;
    endcase
  endfunction

  // n edges, each one hold clocks after the one before
  task automatic step_encoder(input bit fwd, input int n, input int hold);
    int i;
    for (i = 0; i < n; i++) begin
      enc_idx = fwd ? (enc_idx + 1) % 4 : (enc_idx + 3) % 4;
      repeat (hold) @(posedge clk);
      {a, b} <= gray_state(enc_idx);
      if (counting) exp_pos = fwd ? exp_pos + 1 : exp_pos - 1;
    end
  endtask

  task automatic wait_settle();
    repeat (PIN_TO_REG + 1) @(posedge clk);  // decoder path is fixed length
  endtask

  // one apb transfer, setup then access; samples on the falling edge
  task automatic apb_xfer(input logic wr, input logic [`ENC_APB_AW-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int waits;
    waits = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready && waits < PREADY_MAX) begin
      @(negedge clk);
      waits++;
    end
    if (!pready) begin
      $display("%s: APB access to 0x%02h never got pready", test_name, addr);
      test_errs++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [`ENC_APB_AW-1:0] addr, output logic [31:0] rdata,
                          output logic err);
    apb_xfer(1'b0, addr, 32'd0, rdata, err);
  endtask

  task automatic apb_write(input logic [`ENC_APB_AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused_rd;
    apb_xfer(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, got);
      test_errs++;
    end
  endtask

  // interval reads carry +-tol ticks of prescaler phase
  task automatic check_near(input string what, input int exp, input int got, input int tol);
    assert (got >= exp - tol && got <= exp + tol) else begin
      $display("[ERROR] %s %s: expected %0d (+-%0d), actual %0d", test_name, what, exp, tol,
               got);
      test_errs++;
    end
  endtask

  task automatic read_check(input logic [`ENC_APB_AW-1:0] addr, input string what,
                            input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_read(addr, rd, err);
    check_eq(what, exp, rd);
    check_eq({what, " pslverr"}, 32'd0, {31'd0, err});
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %-14s %s", test_name, (test_errs == 0) ? "PASS" : "FAIL");
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    int          n;
    rst          = 1'b1;
    a            = 1'b0;
    b            = 1'b0;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    enc_idx      = 0;
    exp_pos      = 0;
    counting     = 1'b1;
    tests_run    = 0;
    tests_failed = 0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    begin_test("reset_values");
    read_check(`ENC_ADDR_POS, "POS", 32'd0);
    read_check(`ENC_ADDR_PER, "PER", 32'd0);
    read_check(`ENC_ADDR_PREV, "PREV", 32'd0);
    read_check(`ENC_ADDR_CTRL, "CTRL", 32'd1);
    end_test();

    begin_test("count_up_down");
    n = 8 + (($random(seed) & 32'h7fff_ffff) % 33);  // 8..40 edges
    step_encoder(1'b1, n, 16);
    wait_settle();
    read_check(`ENC_ADDR_POS, "POS after forward", 32'(n));
    step_encoder(1'b0, n, 16);
    wait_settle();
    read_check(`ENC_ADDR_POS, "POS after reverse", 32'd0);
    end_test();

    begin_test("period_prev");
    step_encoder(1'b1, 4, 16);
    step_encoder(1'b1, 1, 32);  // back to back, last two gaps 16 then 32
    wait_settle();
    apb_read(`ENC_ADDR_PER, rd, err);
    check_near("PER at S=32", 32 / `ENC_TICK_DIV, int'(rd[`ENC_PER_W-1:0]), 1);
    apb_read(`ENC_ADDR_PREV, rd, err);
    check_near("PREV at S=16", 16 / `ENC_TICK_DIV, int'(rd[`ENC_PER_W-1:0]), 1);
    check_eq("PREV dir forward", 32'd1, {31'd0, rd[31]});
    step_encoder(1'b0, 3, 32);  // reversal, last two gaps both 32
    wait_settle();
    apb_read(`ENC_ADDR_PER, rd, err);
    check_near("PER reverse", 32 / `ENC_TICK_DIV, int'(rd[`ENC_PER_W-1:0]), 1);
    apb_read(`ENC_ADDR_PREV, rd, err);
    check_near("PREV reverse", 32 / `ENC_TICK_DIV, int'(rd[`ENC_PER_W-1:0]), 1);
    check_eq("PREV dir reverse", 32'd0, {31'd0, rd[31]});
    end_test();

    begin_test("overflow");
    repeat (SAT_SPAN + 100) @(posedge clk);  // stalled axis
    apb_read(`ENC_ADDR_PER, rd, err);
    check_eq("PER ovf set", 32'd1, {31'd0, rd[31]});
    step_encoder(1'b1, 1, 1);
    wait_settle();
    apb_read(`ENC_ADDR_PER, rd, err);
    check_eq("PER ovf cleared", 32'd0, {31'd0, rd[31]});
    check_eq("PER saturated", 32'(`ENC_PER_SAT), 32'(rd[`ENC_PER_W-1:0]));
    end_test();

    begin_test("enable_clear");
    apb_write(`ENC_ADDR_CTRL, 32'd0, err);
    counting = 1'b0;
    read_check(`ENC_ADDR_CTRL, "CTRL disabled", 32'd0);
    step_encoder(1'b1, 6, 16);  // edges keep coming
    wait_settle();
    read_check(`ENC_ADDR_POS, "POS held", 32'(exp_pos));
    apb_write(`ENC_ADDR_CTRL, 32'd3, err);  // enable plus pos_clear
    counting = 1'b1;
    exp_pos  = 0;
    wait_settle();
    read_check(`ENC_ADDR_POS, "POS cleared", 32'd0);
    read_check(`ENC_ADDR_CTRL, "CTRL enabled", 32'd1);
    step_encoder(1'b1, 2, 16);
    wait_settle();
    read_check(`ENC_ADDR_POS, "POS counting again", 32'(exp_pos));
    end_test();

    begin_test("bus_errors");
    apb_read(8'h10, rd, err);
    check_eq("pslverr read 0x10", 32'd1, {31'd0, err});
    apb_write(8'h10, 32'd5, err);
    check_eq("pslverr write 0x10", 32'd1, {31'd0, err});
    apb_write(`ENC_ADDR_POS, 32'h0000_dead, err);
    check_eq("pslverr write POS", 32'd0, {31'd0, err});
    read_check(`ENC_ADDR_POS, "POS after write", 32'(exp_pos));
    end_test();

    $display("%0d tests run, %0d passed, %0d failed, %0d assertion failures", tests_run,
             tests_run - tests_failed, tests_failed, i_enc_top.i_enc_chk.fail_cnt);
    if (tests_failed == 0 && i_enc_top.i_enc_chk.fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles before the tests finished", cycles);
    $display("Test failures found");
    $finish;
  end

endmodule
